// File: tb.f
+incdir+include
src/proc_pkg.sv
src/apb_host_port.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/proc_top.sv
tests/proc_tb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench
VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log is searched for the pass line, so a failed run returns an error
run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/proc_tb.sv
// Testbench for the five-stage 16-bit core
// Loads programs over APB and checks data memory against an ISA model
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module proc_tb;
	import proc_pkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int NUM_TESTS = 6;
	localparam int NUM_RANDOM = 20;
	localparam int MAX_PROG = 40;
	// Each program run gets 10 cycles per instruction slot
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + NUM_RANDOM) * MAX_PROG * 10;
	localparam int POLL_LIMIT = 200;
	localparam logic [11:0] CTRL_ADDR = {`PROC_REGION_CTRL, 10'd0};

	logic clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic err;

	// ISA model state, persists across runs like the DUT
	logic [15:0] mdl_regs [8];
	logic [15:0] mdl_mem [256];
	logic [7:0] touched [$];
	logic [15:0] prog [$];
	int error_count;
	int test_count;
	int failed_tests;
	int test_start_errs;

	proc_top proc_top_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.err     (err)
	);

	always #HALF_PERIOD clk = ~clk;

	function automatic logic [15:0] lbi_instr(input logic [2:0] rd, input logic [7:0] imm);
		return {`PROC_OP_LBI, rd, imm};
	endfunction

	function automatic logic [15:0] itype_instr(input logic [4:0] op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] alu_instr(input logic [1:0] fn, input logic [2:0] rs,
			input logic [2:0] rt, input logic [2:0] rd);
		return {`PROC_OP_ALU, rs, rt, rd, fn};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else begin
			$display("%s", what);
			error_count++;
		end
	endtask

	// One APB transfer, setup then access phase, no wait states
	task automatic apb_xfer(input logic write, input logic [11:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic slverr);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		expect_true(apb_rsp.pready, "pready was low in an access phase");
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic host_dmem_write(input logic [7:0] word, input logic [15:0] data);
		logic [15:0] rd;
		logic se;
		apb_xfer(1'b1, {`PROC_REGION_DMEM, 2'b00, word}, data, rd, se);
		expect_true(!se, "Data memory write while stopped was refused");
		mdl_mem[word] = data;
	endtask

	task automatic load_program();
		logic [15:0] rd;
		logic se;
		foreach (prog[i]) begin
			apb_xfer(1'b1, {`PROC_REGION_IMEM, 2'b00, 8'(i)}, prog[i], rd, se);
			expect_true(!se, "Instruction memory write while stopped was refused");
		end
	endtask

	// Executes the program one instruction at a time, illegal opcodes act as NOP
	task automatic model_run();
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm5;
		logic [15:0] addr;
		for (int i = 0; i < prog.size(); i++) begin
			ins = prog[i];
			if (ins[15:11] == `PROC_OP_HALT)
				break;
			a = mdl_regs[ins[10:8]];
			b = mdl_regs[ins[7:5]];
			imm5 = {{11{ins[4]}}, ins[4:0]};
			addr = a + imm5;
			case (ins[15:11])
				`PROC_OP_ADDI: mdl_regs[ins[7:5]] = a + imm5;
				`PROC_OP_SUBI: mdl_regs[ins[7:5]] = imm5 - a;
				`PROC_OP_ST: begin
					mdl_mem[addr[8:1]] = b;
					touched.push_back(addr[8:1]);
				end
				`PROC_OP_LD: mdl_regs[ins[7:5]] = mdl_mem[addr[8:1]];
				`PROC_OP_LBI: mdl_regs[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
				`PROC_OP_ALU: begin
					case (ins[1:0])
						`PROC_FN_ADD: mdl_regs[ins[4:2]] = a + b;
						`PROC_FN_SUB: mdl_regs[ins[4:2]] = b - a;
						`PROC_FN_XOR: mdl_regs[ins[4:2]] = a ^ b;
						default:      mdl_regs[ins[4:2]] = a & ~b;
					endcase
				end
				default: ;
			endcase
		end
	endtask

	task automatic start_core();
		logic [15:0] rd;
		logic se;
		apb_xfer(1'b1, CTRL_ADDR, 16'h0001, rd, se);
		expect_true(!se, "Start write was refused");
	endtask

	// Polls the status register until halted
	task automatic wait_halted(output logic [15:0] status);
		logic se;
		int polls;
		polls = 0;
		status = '0;
		while (!status[1] && polls < POLL_LIMIT) begin
			apb_xfer(1'b0, CTRL_ADDR, 16'h0000, status, se);
			polls++;
		end
		expect_true(status[1], "Core did not report halted within the poll limit");
		check_value("status.run", {15'd0, status[0]}, 16'h0000);
	endtask

	task automatic compare_dmem();
		logic [15:0] rd;
		logic se;
		foreach (touched[i]) begin
			apb_xfer(1'b0, {`PROC_REGION_DMEM, 2'b00, touched[i]}, 16'h0000, rd, se);
			check_value($sformatf("dmem[%h]", touched[i]), rd, mdl_mem[touched[i]]);
		end
		touched.delete();
	endtask

	task automatic run_and_check();
		logic [15:0] status;
		load_program();
		model_run();
		start_core();
		wait_halted(status);
		compare_dmem();
	endtask

	// Every register stored at r0 plus twice its index, then HALT
	task automatic append_stores();
		for (int k = 0; k < 8; k++)
			prog.push_back(itype_instr(`PROC_OP_ST, 3'd0, 3'(k), 5'(2 * k)));
		prog.push_back({`PROC_OP_HALT, 11'd0});
	endtask

	task automatic build_random_program();
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] fn;
		logic [7:0] imm;
		prog.delete();
		prog.push_back(lbi_instr(3'd0, 8'h10));
		for (int i = 0; i < 16; i++) begin
			rs = 3'($urandom_range(0, 7));
			rt = 3'($urandom_range(0, 7));
			rd = 3'($urandom_range(1, 7));
			fn = 2'($urandom_range(0, 3));
			imm = 8'($urandom_range(0, 255));
			if ($urandom_range(0, 3) == 0)
				prog.push_back(lbi_instr(rd, imm));
			else
				prog.push_back(alu_instr(fn, rs, rt, rd));
		end
		append_stores();
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count != test_start_errs) begin
			failed_tests++;
			$display("Test %0d %s: FAILED, %0d errors", test_count, name,
				error_count - test_start_errs);
		end else begin
			$display("Test %0d %s: ok", test_count, name);
		end
		test_start_errs = error_count;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [15:0] rd;
		logic [15:0] status;
		logic se;
		clk = 1'b0;
		rst_n = 1'b0;
		apb_req = '0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		test_start_errs = 0;
		void'($urandom(81));
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Idle bus and status after reset, host access while stopped
		check_value("prdata", apb_rsp.prdata, 16'h0000);
		expect_true(!apb_rsp.pready && !apb_rsp.pslverr, "pready or pslverr high when idle");
		apb_xfer(1'b0, CTRL_ADDR, 16'h0000, rd, se);
		check_value("status", rd, 16'h0000);
		check_value("err", {15'd0, err}, 16'h0000);
		host_dmem_write(8'h30, 16'hA5C3);
		apb_xfer(1'b0, {`PROC_REGION_DMEM, 10'h030}, 16'h0000, rd, se);
		check_value("dmem[30]", rd, 16'hA5C3);
		expect_true(!se, "Data memory read while stopped was refused");
		apb_xfer(1'b0, 12'hC00, 16'h0000, rd, se);
		expect_true(se, "No pslverr on an unmapped region");
		finish_test("reset and host access");

		// Dependent ALU chain on every forwarding path
		prog.delete();
		prog.push_back(lbi_instr(3'd0, 8'h40));
		for (int r = 1; r < 8; r++)
			prog.push_back(lbi_instr(3'(r), 8'(37 * r + 5)));
		prog.push_back(alu_instr(`PROC_FN_ADD, 3'd1, 3'd2, 3'd3));
		prog.push_back(alu_instr(`PROC_FN_SUB, 3'd3, 3'd1, 3'd4));
		prog.push_back(alu_instr(`PROC_FN_XOR, 3'd4, 3'd3, 3'd5));
		prog.push_back(alu_instr(`PROC_FN_ANDN, 3'd5, 3'd4, 3'd6));
		prog.push_back(itype_instr(`PROC_OP_ADDI, 3'd6, 3'd7, 5'h1D));
		prog.push_back(itype_instr(`PROC_OP_SUBI, 3'd7, 3'd1, 5'd9));
		prog.push_back(alu_instr(`PROC_FN_ADD, 3'd1, 3'd7, 3'd2));
		append_stores();
		run_and_check();
		finish_test("dependent ALU chain");

		// Load-use stalls on an ALU source and on store data
		host_dmem_write(8'h38, 16'h1234);
		host_dmem_write(8'h39, 16'hFEDC);
		prog.delete();
		prog.push_back(lbi_instr(3'd1, 8'h70));
		prog.push_back(itype_instr(`PROC_OP_LD, 3'd1, 3'd2, 5'd0));
		prog.push_back(alu_instr(`PROC_FN_ADD, 3'd2, 3'd2, 3'd3));
		prog.push_back(itype_instr(`PROC_OP_ST, 3'd1, 3'd3, 5'd4));
		prog.push_back(itype_instr(`PROC_OP_LD, 3'd1, 3'd4, 5'd2));
		prog.push_back(itype_instr(`PROC_OP_ST, 3'd1, 3'd4, 5'd6));
		prog.push_back(itype_instr(`PROC_OP_LD, 3'd1, 3'd5, 5'd4));
		prog.push_back(itype_instr(`PROC_OP_SUBI, 3'd5, 3'd6, 5'd1));
		prog.push_back(itype_instr(`PROC_OP_ST, 3'd1, 3'd6, 5'd8));
		prog.push_back({`PROC_OP_HALT, 11'd0});
		run_and_check();
		finish_test("load-use stall");

		for (int p = 0; p < NUM_RANDOM; p++) begin
			build_random_program();
			run_and_check();
		end
		finish_test("random programs");

		// Host access is refused while the core runs
		host_dmem_write(8'hF0, 16'h1111);
		prog.delete();
		prog.push_back(lbi_instr(3'd0, 8'h10));
		prog.push_back(lbi_instr(3'd1, 8'h00));
		for (int i = 0; i < 10; i++)
			prog.push_back(itype_instr(`PROC_OP_ADDI, 3'd1, 3'd1, 5'd3));
		prog.push_back(itype_instr(`PROC_OP_ST, 3'd0, 3'd1, 5'd0));
		prog.push_back({`PROC_OP_HALT, 11'd0});
		load_program();
		model_run();
		start_core();
		apb_xfer(1'b1, {`PROC_REGION_DMEM, 10'h0F0}, 16'h2222, rd, se);
		expect_true(se, "No pslverr on a data memory write while running");
		apb_xfer(1'b0, {`PROC_REGION_IMEM, 10'h000}, 16'h0000, rd, se);
		expect_true(se, "No pslverr on an instruction memory read while running");
		wait_halted(status);
		touched.push_back(8'hF0);
		compare_dmem();
		build_random_program();
		run_and_check();
		finish_test("access while running and restart");

		// Illegal opcode sets err until the next start
		prog.delete();
		prog.push_back(lbi_instr(3'd0, 8'h10));
		prog.push_back(16'h3800);
		prog.push_back(lbi_instr(3'd2, 8'h5A));
		prog.push_back(itype_instr(`PROC_OP_ST, 3'd0, 3'd2, 5'd0));
		prog.push_back({`PROC_OP_HALT, 11'd0});
		load_program();
		model_run();
		start_core();
		wait_halted(status);
		check_value("status", status, 16'h0006);
		check_value("err", {15'd0, err}, 16'h0001);
		compare_dmem();
		build_random_program();
		load_program();
		model_run();
		start_core();
		check_value("err", {15'd0, err}, 16'h0000);
		wait_halted(status);
		check_value("status", status, 16'h0002);
		compare_dmem();
		finish_test("illegal opcode");

		$display("Tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/proc_top.sv
// Five-stage 16-bit core with an APB host port
// Joins the stages, the hazard unit and the bus slave
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module proc_top (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire proc_pkg::apb_req_t apb_req,
	output proc_pkg::apb_rsp_t     apb_rsp,
	output logic                   err
);
	import proc_pkg::*;

	host_mem_t imem_host;
	host_mem_t dmem_host;
	logic [`PROC_WORD_W-1:0] dmem_rdata;
	logic [`PROC_WORD_W-1:0] mem_fwd;
	logic [`PROC_REG_W-1:0] dec_rs;
	logic [`PROC_REG_W-1:0] dec_rt;
	logic run;
	logic start;
	logic stall;
	logic halt_seen;
	logic halt_done;
	logic illegal;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	wb_t     wb;

	apb_host_port apb_host_port_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.imem_host  (imem_host),
		.dmem_host  (dmem_host),
		.dmem_rdata (dmem_rdata),
		.halt_done  (halt_done),
		.illegal    (illegal),
		.run        (run),
		.start      (start),
		.err        (err)
	);

	fetch_stage fetch_stage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.start     (start),
		.stall     (stall),
		.halt_seen (halt_seen),
		.imem_host (imem_host),
		.if_id     (if_id)
	);

	decode_stage decode_stage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.start     (start),
		.stall     (stall),
		.if_id     (if_id),
		.wb        (wb),
		.id_ex     (id_ex),
		.halt_seen (halt_seen),
		.illegal   (illegal),
		.dec_rs    (dec_rs),
		.dec_rt    (dec_rt)
	);

	execute_stage execute_stage_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.run     (run),
		.start   (start),
		.id_ex   (id_ex),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.mem_fwd (mem_fwd),
		.wb      (wb),
		.ex_mem  (ex_mem)
	);

	memory_stage memory_stage_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.start      (start),
		.ex_mem     (ex_mem),
		.dmem_host  (dmem_host),
		.dmem_rdata (dmem_rdata),
		.mem_fwd    (mem_fwd),
		.wb         (wb),
		.halt_done  (halt_done)
	);

	hazard_unit hazard_unit_inst (
		.dec_rs (dec_rs),
		.dec_rt (dec_rt),
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.wb     (wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b),
		.stall  (stall)
	);

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
// Hazard unit with the EX operand forwarding selects and the load-use stall
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module hazard_unit (
	input  wire logic [`PROC_REG_W-1:0] dec_rs,
	input  wire logic [`PROC_REG_W-1:0] dec_rt,
	input  wire proc_pkg::id_ex_t       id_ex,
	input  wire proc_pkg::ex_mem_t      ex_mem,
	input  wire proc_pkg::wb_t          wb,
	output proc_pkg::fwd_sel_e          fwd_a,
	output proc_pkg::fwd_sel_e          fwd_b,
	output logic                        stall
);
	import proc_pkg::*;

	function automatic fwd_sel_e route(input logic [`PROC_REG_W-1:0] src);
		// Younger producer wins
		if (ex_mem.ctrl.reg_write && ex_mem.rd == src)
			return FROM_MEM;
		else if (wb.reg_write && wb.rd == src)
			return FROM_WB;
		else
			return REGFILE;
	endfunction

	always_comb begin
		fwd_a = route(id_ex.rs);
		fwd_b = route(id_ex.rt);
	end

	// Load data only exists after the memory stage
	assign stall = id_ex.ctrl.mem_read && (id_ex.rd == dec_rs || id_ex.rd == dec_rt);

endmodule

`default_nettype wire

// File: src/memory_stage.sv
// Memory stage: data memory, MEM/WB register and writeback select
// The host reaches the same memory while the core is stopped
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module memory_stage (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                run,
	input  wire logic                start,
	input  wire proc_pkg::ex_mem_t   ex_mem,
	input  wire proc_pkg::host_mem_t dmem_host,
	output logic [`PROC_WORD_W-1:0]  dmem_rdata,
	output logic [`PROC_WORD_W-1:0]  mem_fwd,
	output proc_pkg::wb_t            wb,
	output logic                     halt_done
);
	import proc_pkg::*;

	localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

	logic [`PROC_WORD_W-1:0] dmem [`PROC_DMEM_DEPTH];
	logic [DMEM_AW-1:0] core_addr;
	logic [`PROC_WORD_W-1:0] load_data;
	mem_wb_t mem_wb;

	// Word address from the byte address
	assign core_addr = ex_mem.result[DMEM_AW:1];
	assign load_data = dmem[core_addr];
	assign dmem_rdata = dmem[dmem_host.addr];
	assign mem_fwd = ex_mem.result;

	always_ff @(posedge clk) begin
		if (dmem_host.wr_en)
			dmem[dmem_host.addr] <= dmem_host.data;
		else if (run && ex_mem.ctrl.mem_write)
			dmem[core_addr] <= ex_mem.store_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			mem_wb <= '0;
		end else if (run) begin
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.rd <= ex_mem.rd;
			mem_wb.wdata <= ex_mem.ctrl.mem_read ? load_data : ex_mem.result;
			mem_wb.halt <= ex_mem.ctrl.halt;
		end
	end

	assign wb.reg_write = mem_wb.reg_write;
	assign wb.rd = mem_wb.rd;
	assign wb.data = mem_wb.wdata;
	assign halt_done = mem_wb.halt;

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// Execute stage: operand forwarding, ALU and the EX/MEM register
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module execute_stage (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    run,
	input  wire logic                    start,
	input  wire proc_pkg::id_ex_t        id_ex,
	input  wire proc_pkg::fwd_sel_e      fwd_a,
	input  wire proc_pkg::fwd_sel_e      fwd_b,
	input  wire logic [`PROC_WORD_W-1:0] mem_fwd,
	input  wire proc_pkg::wb_t           wb,
	output proc_pkg::ex_mem_t            ex_mem
);
	import proc_pkg::*;

	logic [`PROC_WORD_W-1:0] opnd_a;
	logic [`PROC_WORD_W-1:0] opnd_b;
	logic [`PROC_WORD_W-1:0] alu_b;
	logic [`PROC_WORD_W-1:0] result;

	function automatic logic [`PROC_WORD_W-1:0] pick(input fwd_sel_e sel,
			input logic [`PROC_WORD_W-1:0] rf_val,
			input logic [`PROC_WORD_W-1:0] mem_val,
			input logic [`PROC_WORD_W-1:0] wb_val);
		case (sel)
			FROM_MEM: return mem_val;
			FROM_WB:  return wb_val;
			default:  return rf_val;
		endcase
	endfunction

	assign opnd_a = pick(fwd_a, id_ex.op_a, mem_fwd, wb.data);
	assign opnd_b = pick(fwd_b, id_ex.op_b, mem_fwd, wb.data);
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : opnd_b;

	// SUB and SUBI take the second operand minus the first
	always_comb begin
		case (id_ex.ctrl.alu_op)
			SUB:     result = alu_b - opnd_a;
			XOR:     result = opnd_a ^ alu_b;
			ANDN:    result = opnd_a & ~alu_b;
			PASS_B:  result = alu_b;
			default: result = opnd_a + alu_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			ex_mem <= '0;
		end else if (run) begin
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.result <= result;
			ex_mem.store_data <= opnd_b;
			ex_mem.rd <= id_ex.rd;
		end
	end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// Decode stage: opcode decoder, bypassing register file, ID/EX register
// Unknown opcodes decode as NOP and raise illegal
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module decode_stage (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   run,
	input  wire logic                   start,
	input  wire logic                   stall,
	input  wire proc_pkg::if_id_t       if_id,
	input  wire proc_pkg::wb_t          wb,
	output proc_pkg::id_ex_t            id_ex,
	output logic                        halt_seen,
	output logic                        illegal,
	output logic [`PROC_REG_W-1:0]      dec_rs,
	output logic [`PROC_REG_W-1:0]      dec_rt
);
	import proc_pkg::*;

	logic [`PROC_WORD_W-1:0] regs [`PROC_REG_CNT];
	logic [`PROC_WORD_W-1:0] instr;
	logic [4:0] opcode;
	logic [1:0] funct;
	ctrl_t ctrl;
	logic [`PROC_REG_W-1:0] rd;
	logic [`PROC_WORD_W-1:0] imm;
	logic known;
	logic [`PROC_WORD_W-1:0] val_a;
	logic [`PROC_WORD_W-1:0] val_b;

	assign instr = if_id.instr;
	assign opcode = instr[15:11];
	assign funct = instr[1:0];
	assign dec_rs = instr[10:8];
	assign dec_rt = instr[7:5];

	always_comb begin
		ctrl = '0;
		rd = instr[7:5];
		imm = {{11{instr[4]}}, instr[4:0]};
		known = 1'b1;
		case (opcode)
			`PROC_OP_HALT: ctrl.halt = 1'b1;
			`PROC_OP_NOP: ;
			`PROC_OP_ADDI, `PROC_OP_SUBI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = (opcode == `PROC_OP_SUBI) ? SUB : ADD;
			end
			`PROC_OP_ST: begin
				ctrl.mem_write = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			`PROC_OP_LD: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			`PROC_OP_LBI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = PASS_B;
				rd = instr[10:8];
				imm = {{8{instr[7]}}, instr[7:0]};
			end
			`PROC_OP_ALU: begin
				ctrl.reg_write = 1'b1;
				rd = instr[4:2];
				case (funct)
					`PROC_FN_ADD: ctrl.alu_op = ADD;
					`PROC_FN_SUB: ctrl.alu_op = SUB;
					`PROC_FN_XOR: ctrl.alu_op = XOR;
					default:      ctrl.alu_op = ANDN;
				endcase
			end
			default: known = 1'b0;
		endcase
	end

	assign halt_seen = ctrl.halt;
	assign illegal = run & ~known;

	always_ff @(posedge clk) begin
		if (run && wb.reg_write)
			regs[wb.rd] <= wb.data;
	end

	// Writeback result is visible in the same cycle
	assign val_a = (wb.reg_write && wb.rd == dec_rs) ? wb.data : regs[dec_rs];
	assign val_b = (wb.reg_write && wb.rd == dec_rt) ? wb.data : regs[dec_rt];

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			id_ex <= '0;
		end else if (run) begin
			if (stall) begin
				// Bubble while the load result is pending
				id_ex <= '0;
			end else begin
				id_ex.ctrl <= ctrl;
				id_ex.op_a <= val_a;
				id_ex.op_b <= val_b;
				id_ex.rs <= dec_rs;
				id_ex.rt <= dec_rt;
				id_ex.rd <= rd;
				id_ex.imm <= imm;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// Fetch stage with the byte PC and the instruction memory
// Feeds NOPs once HALT has reached decode
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module fetch_stage (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                run,
	input  wire logic                start,
	input  wire logic                stall,
	input  wire logic                halt_seen,
	input  wire proc_pkg::host_mem_t imem_host,
	output proc_pkg::if_id_t         if_id
);
	import proc_pkg::*;

	localparam int IMEM_AW = $clog2(`PROC_IMEM_DEPTH);
	localparam logic [`PROC_WORD_W-1:0] NOP_INSTR = {`PROC_OP_NOP, 11'd0};

	logic [`PROC_WORD_W-1:0] imem [`PROC_IMEM_DEPTH];
	logic [`PROC_WORD_W-1:0] pc;
	logic [`PROC_WORD_W-1:0] pc_next;
	logic halt_q;
	logic drain;
	if_id_t if_id_d;

	assign pc_next = pc + 16'd2;
	assign drain = halt_seen | halt_q;

	// Program load from the host
	always_ff @(posedge clk) begin
		if (imem_host.wr_en)
			imem[imem_host.addr] <= imem_host.data;
	end

	always_comb begin
		if_id_d.instr = drain ? NOP_INSTR : imem[pc[IMEM_AW:1]];
		if_id_d.next_pc = pc_next;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			pc <= '0;
			halt_q <= 1'b0;
			if_id.instr <= NOP_INSTR;
			if_id.next_pc <= '0;
		end else if (run && !stall) begin
			// PC parks after HALT
			if (!drain)
				pc <= pc_next;
			halt_q <= drain;
			if_id <= if_id_d;
		end
	end

endmodule

`default_nettype wire

// File: src/apb_host_port.sv
// APB slave for the core: run/status register and host memory access
// Memory accesses are refused with pslverr while the core runs
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module apb_host_port (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire proc_pkg::apb_req_t      apb_req,
	output proc_pkg::apb_rsp_t           apb_rsp,
	output proc_pkg::host_mem_t          imem_host,
	output proc_pkg::host_mem_t          dmem_host,
	input  wire logic [`PROC_WORD_W-1:0] dmem_rdata,
	input  wire logic                    halt_done,
	input  wire logic                    illegal,
	output logic                         run,
	output logic                         start,
	output logic                         err
);
	import proc_pkg::*;

	logic [1:0] region;
	logic access;
	logic mem_region;
	logic bad;
	logic ctrl_wr;
	logic halted;
	host_mem_t host_acc;

	assign region = apb_req.paddr[`PROC_APB_ADDR_W-1:`PROC_APB_ADDR_W-2];
	assign access = apb_req.psel & apb_req.penable;
	assign mem_region = (region == `PROC_REGION_IMEM) || (region == `PROC_REGION_DMEM);
	assign bad = (mem_region && run) || (region == 2'd3);
	assign ctrl_wr = access && apb_req.pwrite && (region == `PROC_REGION_CTRL);

	// One access, steered to whichever memory the region selects
	assign host_acc.wr_en = access && apb_req.pwrite && !bad;
	assign host_acc.addr = apb_req.paddr[$bits(host_acc.addr)-1:0];
	assign host_acc.data = apb_req.pwdata;

	always_comb begin
		imem_host = host_acc;
		dmem_host = host_acc;
		imem_host.wr_en = host_acc.wr_en && (region == `PROC_REGION_IMEM);
		dmem_host.wr_en = host_acc.wr_en && (region == `PROC_REGION_DMEM);
	end

	// No wait states
	always_comb begin
		apb_rsp = '0;
		apb_rsp.pready = access;
		apb_rsp.pslverr = access && bad;
		if (access && !apb_req.pwrite && !bad) begin
			case (region)
				`PROC_REGION_CTRL: apb_rsp.prdata = {13'd0, err, halted, run};
				`PROC_REGION_DMEM: apb_rsp.prdata = dmem_rdata;
				default:           apb_rsp.prdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			start <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			start <= 1'b0;
			if (ctrl_wr) begin
				run <= apb_req.pwdata[0];
				if (apb_req.pwdata[0]) begin
					start <= 1'b1;
					halted <= 1'b0;
					err <= 1'b0;
				end
			end else if (run && !start) begin
				// Stale pipeline contents are ignored during the start cycle
				if (halt_done) begin
					run <= 1'b0;
					halted <= 1'b1;
				end
				if (illegal)
					err <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/proc_pkg.sv
// Types shared by the core stages and the APB host port
// Control bundle, pipeline payloads and bus records
`default_nettype none

package proc_pkg;

	`include "proc_defs.svh"

	typedef enum logic [2:0] {
		ADD,
		SUB,
		XOR,
		ANDN,
		PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		REGFILE,
		FROM_MEM,
		FROM_WB
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    use_imm;
		alu_op_e alu_op;
		logic    halt;
	} ctrl_t;

	typedef struct packed {
		logic [`PROC_WORD_W-1:0] instr;
		logic [`PROC_WORD_W-1:0] next_pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`PROC_WORD_W-1:0] op_a;
		logic [`PROC_WORD_W-1:0] op_b;
		logic [`PROC_REG_W-1:0]  rs;
		logic [`PROC_REG_W-1:0]  rt;
		logic [`PROC_REG_W-1:0]  rd;
		logic [`PROC_WORD_W-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`PROC_WORD_W-1:0] result;
		logic [`PROC_WORD_W-1:0] store_data;
		logic [`PROC_REG_W-1:0]  rd;
	} ex_mem_t;

	typedef struct packed {
		logic                    reg_write;
		logic [`PROC_REG_W-1:0]  rd;
		logic [`PROC_WORD_W-1:0] wdata;
		logic                    halt;
	} mem_wb_t;

	// Writeback port, also the oldest forwarding source
	typedef struct packed {
		logic                    reg_write;
		logic [`PROC_REG_W-1:0]  rd;
		logic [`PROC_WORD_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic                        psel;
		logic                        penable;
		logic                        pwrite;
		logic [`PROC_APB_ADDR_W-1:0] paddr;
		logic [`PROC_WORD_W-1:0]     pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`PROC_WORD_W-1:0] prdata;
		logic                    pready;
		logic                    pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic                                 wr_en;
		logic [$clog2(`PROC_IMEM_DEPTH)-1:0]  addr;
		logic [`PROC_WORD_W-1:0]              data;
	} host_mem_t;

endpackage

`default_nettype wire

// File: include/proc_defs.svh
// Shared constants for the 16-bit pipelined core
// Widths, memory depths, opcodes, ALU functs and the APB address map
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

`define PROC_WORD_W      16
`define PROC_REG_CNT     8
`define PROC_REG_W       3
`define PROC_IMEM_DEPTH  256
`define PROC_DMEM_DEPTH  256
`define PROC_APB_ADDR_W  12

// APB region code, held in paddr[11:10]
`define PROC_REGION_CTRL 2'd0
`define PROC_REGION_IMEM 2'd1
`define PROC_REGION_DMEM 2'd2

`define PROC_OP_HALT     5'b00000
`define PROC_OP_NOP      5'b00001
`define PROC_OP_ADDI     5'b01000
`define PROC_OP_SUBI     5'b01001
`define PROC_OP_ST       5'b10000
`define PROC_OP_LD       5'b10001
`define PROC_OP_LBI      5'b11000
`define PROC_OP_ALU      5'b11011

`define PROC_FN_ADD      2'b00
`define PROC_FN_SUB      2'b01
`define PROC_FN_XOR      2'b10
`define PROC_FN_ANDN     2'b11

`endif
